// ==== common/csr_pkg.sv ====
package csr_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] csr_data_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [1:0]  plv_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [6:0]  expcode_t;
    typedef logic [7:0]  hw_irq_t;

    localparam int IRQ_BITS = 13;
    typedef logic [IRQ_BITS-1:0] irq_vec_t;

    // Register numbers
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_BADV   = 14'h7;
    localparam csr_addr_t CSR_EENTRY = 14'hC;
    localparam csr_addr_t CSR_SAVE0  = 14'h30;
    localparam csr_addr_t CSR_SAVE1  = 14'h31;
    localparam csr_addr_t CSR_SAVE2  = 14'h32;
    localparam csr_addr_t CSR_SAVE3  = 14'h33;
    localparam csr_addr_t CSR_TCFG   = 14'h41;
    localparam csr_addr_t CSR_TVAL   = 14'h42;
    localparam csr_addr_t CSR_TICLR  = 14'h44;
    localparam csr_addr_t CSR_LLBCTL = 14'h60;

    // CRMD fields
    localparam int CRMD_IE      = 2;
    localparam int CRMD_DA      = 3;
    localparam int CRMD_PG      = 4;
    localparam int CRMD_DATF_LO = 5;
    localparam int CRMD_DATM_LO = 7;

    // PRMD keeps the old IE here, the old PLV in bits 1:0
    localparam int PRMD_PIE = 2;

    // ECFG local enables; bit 10 is reserved
    localparam irq_vec_t ECFG_LIE_MASK = 13'h1BFF;

    // ESTAT fields
    localparam int TI_BIT           = 11;
    localparam int ESTAT_ECODE_LO   = 16;
    localparam int ESTAT_SUBCODE_LO = 22;

    localparam int EENTRY_VA_LO = 6;

    // TCFG fields, InitVal sits above PERIODIC
    localparam int TCFG_EN       = 0;
    localparam int TCFG_PERIODIC = 1;

    // LLBCTL fields
    localparam int LLBCTL_ROLLB = 0;
    localparam int LLBCTL_WCLLB = 1;
    localparam int LLBCTL_KLO   = 2;

endpackage

// ==== hdl/csr_write_stage.sv ====
`timescale 1ns/1ps

module csr_write_stage (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               wen,
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_data_t wdata,
    input  logic               d_idle,
    input  logic               flush,
    output logic               commit,
    output csr_pkg::csr_addr_t commit_addr,
    output csr_pkg::csr_data_t commit_data,
    output logic               csr_write_start
);

    typedef enum logic [1:0] {
        ST_EMPTY,
        ST_HELD,
        ST_WAIT,
        ST_COMMIT
    } write_stage_t;

    write_stage_t state;

    // A new write restarts the count, flush drops whatever is held
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= ST_EMPTY;
        end else if (flush) begin
            state <= ST_EMPTY;
        end else if (wen) begin
            state <= ST_HELD;
        end else begin
            case (state)
                ST_HELD: begin
                    if (d_idle) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (d_idle) begin
                        state <= ST_COMMIT;
                    end
                end
                ST_COMMIT: state <= ST_EMPTY;
                default:   state <= ST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wen && !flush) begin
            commit_addr <= addr;
            commit_data <= wdata;
        end
    end

    assign commit          = (state == ST_COMMIT);
    assign csr_write_start = (state == ST_HELD) && d_idle;

endmodule

// ==== exception/exception_csr.sv ====
`timescale 1ns/1ps

module exception_csr (
    input  logic                clk,
    input  logic                aresetn,
    input  logic                commit,
    input  csr_pkg::csr_addr_t  commit_addr,
    input  csr_pkg::csr_data_t  commit_data,
    input  logic                exception,
    input  logic                ertn,
    input  logic                wen_expcode,
    input  logic                wen_era,
    input  logic                wen_badv,
    input  csr_pkg::expcode_t   expcode,
    input  csr_pkg::csr_data_t  era_in,
    input  csr_pkg::csr_data_t  badv_in,
    input  csr_pkg::hw_irq_t    hw_irq,
    input  logic                ti,
    output csr_pkg::csr_data_t  crmd,
    output csr_pkg::csr_data_t  prmd,
    output csr_pkg::csr_data_t  ecfg,
    output csr_pkg::csr_data_t  estat,
    output csr_pkg::csr_data_t  era,
    output csr_pkg::csr_data_t  badv,
    output csr_pkg::csr_data_t  eentry,
    output logic                cpu_interrupt,
    output logic                idle_over
);

    logic               exception_q;
    logic               excp_enter;
    csr_pkg::plv_t      crmd_plv;
    logic               crmd_ie;
    logic               crmd_da;
    logic               crmd_pg;
    logic [1:0]         crmd_datf;
    logic [1:0]         crmd_datm;
    csr_pkg::plv_t      prmd_pplv;
    logic               prmd_pie;
    csr_pkg::irq_vec_t  ecfg_lie;
    logic [1:0]         estat_is_soft;
    csr_pkg::ecode_t    estat_ecode;
    logic [8:0]         estat_subcode;
    csr_pkg::irq_vec_t  estat_is;
    logic               soft_irq_q;
    logic [25:0]        eentry_va;
    logic               pg_next;
    logic               da_next;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exception_q <= 1'b0;
            soft_irq_q  <= 1'b0;
        end else begin
            exception_q <= exception;
            soft_irq_q  <= |estat_is_soft;
        end
    end

    assign excp_enter = exception && !exception_q;

    assign pg_next = commit_data[csr_pkg::CRMD_PG];
    assign da_next = commit_data[csr_pkg::CRMD_DA];

    // Return wins over entry, entry wins over a software write
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'd1;
            crmd_datm <= 2'd1;
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (excp_enter) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
            crmd_plv  <= '0;
            crmd_ie   <= 1'b0;
        end else if (commit && commit_addr == csr_pkg::CSR_CRMD) begin
            crmd_plv  <= commit_data[1:0];
            crmd_ie   <= commit_data[csr_pkg::CRMD_IE];
            crmd_datf <= commit_data[csr_pkg::CRMD_DATF_LO +: 2];
            crmd_datm <= commit_data[csr_pkg::CRMD_DATM_LO +: 2];
            // Only a legal translation mode is taken
            if (pg_next ^ da_next) begin
                crmd_pg <= pg_next;
                crmd_da <= da_next;
            end
        end else if (commit && commit_addr == csr_pkg::CSR_PRMD) begin
            prmd_pplv <= commit_data[1:0];
            prmd_pie  <= commit_data[csr_pkg::PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecfg_lie      <= '0;
            estat_is_soft <= '0;
            estat_ecode   <= '0;
            estat_subcode <= '0;
            eentry_va     <= '0;
        end else begin
            if (commit && commit_addr == csr_pkg::CSR_ECFG) begin
                ecfg_lie <= commit_data[csr_pkg::IRQ_BITS-1:0] & csr_pkg::ECFG_LIE_MASK;
            end
            if (wen_expcode || excp_enter) begin
                estat_ecode   <= expcode[5:0];
                estat_subcode <= (expcode[5:0] == '0) ? 9'd0 : {8'd0, expcode[6]};
            end else if (commit && commit_addr == csr_pkg::CSR_ESTAT) begin
                estat_is_soft <= commit_data[1:0];
            end
            if (commit && commit_addr == csr_pkg::CSR_EENTRY) begin
                eentry_va <= commit_data[31:csr_pkg::EENTRY_VA_LO];
            end
        end
    end

    // Skip the trapping instruction when a software interrupt was pending
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            era  <= '0;
            badv <= '0;
        end else begin
            if (wen_era) begin
                era <= soft_irq_q ? era_in + 32'd4 : era_in;
            end else if (commit && commit_addr == csr_pkg::CSR_ERA) begin
                era <= commit_data;
            end
            if (wen_badv) begin
                badv <= badv_in;
            end else if (commit && commit_addr == csr_pkg::CSR_BADV) begin
                badv <= commit_data;
            end
        end
    end

    always_comb begin
        estat_is                 = '0;
        estat_is[1:0]            = estat_is_soft;
        estat_is[9:2]            = hw_irq;
        estat_is[csr_pkg::TI_BIT] = ti;
    end

    assign crmd   = {23'd0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign prmd   = {29'd0, prmd_pie, prmd_pplv};
    assign ecfg   = {19'd0, ecfg_lie};
    assign estat  = {1'b0, estat_subcode, estat_ecode, 3'd0, estat_is};
    assign eentry = {eentry_va, 6'd0};

    assign cpu_interrupt = crmd_ie && |(ecfg_lie & estat_is);
    assign idle_over     = |estat_is;

endmodule

// ==== timer/timer_csr.sv ====
`timescale 1ns/1ps

module timer_csr #(
    parameter int TIMER_RELOAD_BIAS = 100
) (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_data_t commit_data,
    output csr_pkg::csr_data_t tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               ti
);

    logic        tcfg_en;
    logic        tcfg_periodic;
    logic [29:0] tcfg_initval;
    logic        reload;
    logic        time_out;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
            reload        <= 1'b0;
        end else begin
            reload <= commit && commit_addr == csr_pkg::CSR_TCFG;
            if (commit && commit_addr == csr_pkg::CSR_TCFG) begin
                tcfg_en       <= commit_data[csr_pkg::TCFG_EN];
                tcfg_periodic <= commit_data[csr_pkg::TCFG_PERIODIC];
                tcfg_initval  <= commit_data[31:2];
            end
        end
    end

    // Counter stops at zero unless periodic; the bias keeps InitVal 0 usable
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else if (tval == '0 || reload) begin
            time_out <= 1'b0;
            if (tcfg_periodic || reload) begin
                tval <= {2'b00, tcfg_initval} + csr_pkg::csr_data_t'(TIMER_RELOAD_BIAS);
            end
        end else if (tcfg_en) begin
            tval     <= tval - 32'd1;
            time_out <= (tval == 32'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ti <= 1'b0;
        end else if (commit && commit_addr == csr_pkg::CSR_TICLR) begin
            ti <= 1'b0;
        end else if (time_out) begin
            ti <= 1'b1;
        end
    end

    assign tcfg = {tcfg_initval, tcfg_periodic, tcfg_en};

endmodule

// ==== hdl/save_llbit_csr.sv ====
`timescale 1ns/1ps

module save_llbit_csr (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               commit,
    input  csr_pkg::csr_addr_t commit_addr,
    input  csr_pkg::csr_data_t commit_data,
    input  logic               llbit_set,
    input  logic               llbit_clear,
    input  logic               ertn,
    output csr_pkg::csr_data_t save0,
    output csr_pkg::csr_data_t save1,
    output csr_pkg::csr_data_t save2,
    output csr_pkg::csr_data_t save3,
    output csr_pkg::csr_data_t llbctl,
    output logic               llbit
);

    logic rollb;
    logic klo;

    always_ff @(posedge clk) begin
        if (commit) begin
            case (commit_addr)
                csr_pkg::CSR_SAVE0: save0 <= commit_data;
                csr_pkg::CSR_SAVE1: save1 <= commit_data;
                csr_pkg::CSR_SAVE2: save2 <= commit_data;
                csr_pkg::CSR_SAVE3: save3 <= commit_data;
                default: ;
            endcase
        end
    end

    // KLO keeps the LL bit alive across one exception return
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            rollb <= 1'b1;
            klo   <= 1'b0;
        end else if (llbit_set) begin
            rollb <= 1'b1;
        end else if (ertn) begin
            rollb <= klo;
            klo   <= 1'b0;
        end else if (llbit_clear) begin
            rollb <= 1'b0;
        end else if (commit && commit_addr == csr_pkg::CSR_LLBCTL) begin
            if (commit_data[csr_pkg::LLBCTL_WCLLB]) begin
                rollb <= 1'b0;
            end
            klo <= commit_data[csr_pkg::LLBCTL_KLO];
        end
    end

    always_comb begin
        llbctl                        = '0;
        llbctl[csr_pkg::LLBCTL_ROLLB] = rollb;
        llbctl[csr_pkg::LLBCTL_KLO]   = klo;
    end

    assign llbit = rollb || llbit_set;

endmodule

// ==== hdl/csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux (
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_data_t crmd,
    input  csr_pkg::csr_data_t prmd,
    input  csr_pkg::csr_data_t ecfg,
    input  csr_pkg::csr_data_t estat,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t badv,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t tcfg,
    input  csr_pkg::csr_data_t tval,
    input  csr_pkg::csr_data_t llbctl,
    input  csr_pkg::csr_data_t save0,
    input  csr_pkg::csr_data_t save1,
    input  csr_pkg::csr_data_t save2,
    input  csr_pkg::csr_data_t save3,
    output csr_pkg::csr_data_t rdata
);

    always_comb begin
        case (addr)
            csr_pkg::CSR_CRMD:   rdata = crmd;
            csr_pkg::CSR_PRMD:   rdata = prmd;
            csr_pkg::CSR_ECFG:   rdata = ecfg & {19'd0, csr_pkg::ECFG_LIE_MASK};
            csr_pkg::CSR_ESTAT:  rdata = estat;
            csr_pkg::CSR_ERA:    rdata = era;
            csr_pkg::CSR_BADV:   rdata = badv;
            csr_pkg::CSR_EENTRY: rdata = eentry;
            csr_pkg::CSR_SAVE0:  rdata = save0;
            csr_pkg::CSR_SAVE1:  rdata = save1;
            csr_pkg::CSR_SAVE2:  rdata = save2;
            csr_pkg::CSR_SAVE3:  rdata = save3;
            csr_pkg::CSR_TCFG:   rdata = tcfg;
            csr_pkg::CSR_TVAL:   rdata = tval;
            // Write-only clear register
            csr_pkg::CSR_TICLR:  rdata = '0;
            csr_pkg::CSR_LLBCTL: rdata = llbctl;
            default:             rdata = '0;
        endcase
    end

endmodule

// ==== hdl/csr_top.sv ====
`timescale 1ns/1ps

module csr_top #(
    parameter int TIMER_RELOAD_BIAS = 100
) (
    input  logic               clk,
    input  logic               aresetn,
    input  logic               wen,
    input  logic               d_idle,
    input  logic               flush,
    input  csr_pkg::csr_addr_t addr,
    input  csr_pkg::csr_data_t wdata,
    input  logic               exception,
    input  logic               ertn,
    input  logic               wen_expcode,
    input  csr_pkg::expcode_t  expcode,
    input  logic               wen_era,
    input  csr_pkg::csr_data_t era_in,
    input  logic               wen_badv,
    input  csr_pkg::csr_data_t badv_in,
    input  logic               llbit_set,
    input  logic               llbit_clear,
    input  csr_pkg::hw_irq_t   hw_irq,
    output csr_pkg::csr_data_t rdata,
    output csr_pkg::csr_data_t crmd,
    output csr_pkg::csr_data_t estat,
    output csr_pkg::csr_data_t era,
    output csr_pkg::csr_data_t eentry,
    output logic               cpu_interrupt,
    output logic               idle_over,
    output logic               llbit,
    output logic               csr_write_start
);

    logic               commit;
    csr_pkg::csr_addr_t commit_addr;
    csr_pkg::csr_data_t commit_data;
    csr_pkg::csr_data_t prmd, ecfg, badv, tcfg, tval, llbctl;
    csr_pkg::csr_data_t save0, save1, save2, save3;
    logic               ti;

    csr_write_stage i_write_stage (
        .clk(clk), .aresetn(aresetn), .wen(wen), .addr(addr), .wdata(wdata),
        .d_idle(d_idle), .flush(flush), .commit(commit), .commit_addr(commit_addr),
        .commit_data(commit_data), .csr_write_start(csr_write_start)
    );

    exception_csr i_exception_csr (
        .clk(clk), .aresetn(aresetn), .commit(commit), .commit_addr(commit_addr),
        .commit_data(commit_data), .exception(exception), .ertn(ertn),
        .wen_expcode(wen_expcode), .wen_era(wen_era), .wen_badv(wen_badv),
        .expcode(expcode), .era_in(era_in), .badv_in(badv_in), .hw_irq(hw_irq), .ti(ti),
        .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat), .era(era), .badv(badv),
        .eentry(eentry), .cpu_interrupt(cpu_interrupt), .idle_over(idle_over)
    );

    timer_csr #(.TIMER_RELOAD_BIAS(TIMER_RELOAD_BIAS)) i_timer_csr (
        .clk(clk), .aresetn(aresetn), .commit(commit), .commit_addr(commit_addr),
        .commit_data(commit_data), .tcfg(tcfg), .tval(tval), .ti(ti)
    );

    save_llbit_csr i_save_llbit_csr (
        .clk(clk), .aresetn(aresetn), .commit(commit), .commit_addr(commit_addr),
        .commit_data(commit_data), .llbit_set(llbit_set), .llbit_clear(llbit_clear),
        .ertn(ertn), .save0(save0), .save1(save1), .save2(save2), .save3(save3),
        .llbctl(llbctl), .llbit(llbit)
    );

    csr_read_mux i_read_mux (
        .addr(addr), .crmd(crmd), .prmd(prmd), .ecfg(ecfg), .estat(estat), .era(era),
        .badv(badv), .eentry(eentry), .tcfg(tcfg), .tval(tval), .llbctl(llbctl),
        .save0(save0), .save1(save1), .save2(save2), .save3(save3), .rdata(rdata)
    );

endmodule

// ==== sim/csr_checker.sv ====
`timescale 1ns/1ps

module csr_checker (
    input  logic               clk,
    input  logic               check,
    input  logic               timeout_evt,
    input  logic               done,
    input  logic [3:0]         sel,
    input  csr_pkg::csr_data_t expected,
    input  csr_pkg::csr_data_t rdata,
    input  csr_pkg::csr_data_t crmd,
    input  csr_pkg::csr_data_t estat,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t eentry,
    input  logic               cpu_interrupt,
    input  logic               idle_over,
    input  logic               llbit,
    input  logic               csr_write_start,
    output int                 fail_count
);

    int                 test_count;
    int                 pass_count;
    csr_pkg::csr_data_t actual;

    function automatic string signal_name(input logic [3:0] code);
        case (code)
            4'h0:    return "rdata";
            4'h1:    return "crmd";
            4'h2:    return "estat";
            4'h3:    return "era";
            4'h4:    return "eentry";
            4'h5:    return "cpu_interrupt";
            4'h6:    return "idle_over";
            4'h7:    return "llbit";
            4'h8:    return "csr_write_start";
            default: return "unknown";
        endcase
    endfunction

    always_comb begin
        case (sel)
            4'h0:    actual = rdata;
            4'h1:    actual = crmd;
            4'h2:    actual = estat;
            4'h3:    actual = era;
            4'h4:    actual = eentry;
            4'h5:    actual = {31'd0, cpu_interrupt};
            4'h6:    actual = {31'd0, idle_over};
            4'h7:    actual = {31'd0, llbit};
            4'h8:    actual = {31'd0, csr_write_start};
            default: actual = '0;
        endcase
    end

    initial begin
        test_count = 0;
        pass_count = 0;
        fail_count = 0;
    end

    // Sampled on the rising edge, the values are those settled since the falling edge
    always @(posedge clk) begin
        if (check) begin
            test_count = test_count + 1;
            if (actual === expected) begin
                pass_count = pass_count + 1;
                $display("test %0d ok: %s = 0x%08h", test_count, signal_name(sel), actual);
            end else begin
                fail_count = fail_count + 1;
                $display("mismatch %s: expected 0x%08h, got 0x%08h (test %0d)",
                         signal_name(sel), expected, actual, test_count);
            end
        end
        if (timeout_evt) begin
            test_count = test_count + 1;
            fail_count = fail_count + 1;
            $display("test %0d failed: the timer interrupt never showed up on %s in time",
                     test_count, signal_name(sel));
        end
        if (done) begin
            $display("%0d tests run, %0d passed, %0d failed",
                     test_count, pass_count, fail_count);
        end
    end

endmodule

// ==== sim/tb_csr.sv ====
`timescale 1ns/1ps

module tb_csr;

    localparam int PERIOD          = 40;
    localparam int TIMER_BIAS      = 20;
    localparam int CYCLES_PER_STEP = 400;

    localparam logic [3:0] OP_WRITE     = 4'h0;
    localparam logic [3:0] OP_CHECK     = 4'h1;
    localparam logic [3:0] OP_EXCEPTION = 4'h2;
    localparam logic [3:0] OP_ERTN      = 4'h3;
    localparam logic [3:0] OP_IRQ       = 4'h4;
    localparam logic [3:0] OP_LLBIT     = 4'h5;
    localparam logic [3:0] OP_FLUSH     = 4'h6;
    localparam logic [3:0] OP_TIMER     = 4'h7;
    localparam logic [3:0] SEL_WRITE_START = 4'h8;
    localparam logic [3:0] NO_CHECK     = 4'hf;

    typedef struct packed {
        logic [3:0]         op;
        logic [3:0]         sel;
        logic [31:0]        arg;
        csr_pkg::csr_data_t data;
        csr_pkg::csr_data_t expected;
    } step_t;

    logic               clk;
    logic               aresetn;
    logic               wen;
    logic               d_idle;
    logic               flush;
    csr_pkg::csr_addr_t addr;
    csr_pkg::csr_data_t wdata;
    logic               exception;
    logic               ertn;
    logic               wen_expcode;
    csr_pkg::expcode_t  expcode;
    logic               wen_era;
    csr_pkg::csr_data_t era_in;
    logic               wen_badv;
    csr_pkg::csr_data_t badv_in;
    logic               llbit_set;
    logic               llbit_clear;
    csr_pkg::hw_irq_t   hw_irq;
    csr_pkg::csr_data_t rdata;
    csr_pkg::csr_data_t crmd;
    csr_pkg::csr_data_t estat;
    csr_pkg::csr_data_t era;
    csr_pkg::csr_data_t eentry;
    logic               cpu_interrupt;
    logic               idle_over;
    logic               llbit;
    logic               csr_write_start;

    logic               check;
    logic               timeout_evt;
    logic               done;
    logic [3:0]         chk_sel;
    csr_pkg::csr_data_t chk_exp;
    int                 fail_count;

    step_t              steps[$];
    bit                 loaded = 1'b0;
    int                 watchdog_cycles;
    int                 timer_limit;

    csr_top #(.TIMER_RELOAD_BIAS(TIMER_BIAS)) i_dut (
        .clk(clk), .aresetn(aresetn), .wen(wen), .d_idle(d_idle), .flush(flush),
        .addr(addr), .wdata(wdata), .exception(exception), .ertn(ertn),
        .wen_expcode(wen_expcode), .expcode(expcode), .wen_era(wen_era), .era_in(era_in),
        .wen_badv(wen_badv), .badv_in(badv_in), .llbit_set(llbit_set),
        .llbit_clear(llbit_clear), .hw_irq(hw_irq), .rdata(rdata), .crmd(crmd),
        .estat(estat), .era(era), .eentry(eentry), .cpu_interrupt(cpu_interrupt),
        .idle_over(idle_over), .llbit(llbit), .csr_write_start(csr_write_start)
    );

    csr_checker i_checker (
        .clk(clk), .check(check), .timeout_evt(timeout_evt), .done(done),
        .sel(chk_sel), .expected(chk_exp), .rdata(rdata), .crmd(crmd), .estat(estat),
        .era(era), .eentry(eentry), .cpu_interrupt(cpu_interrupt), .idle_over(idle_over),
        .llbit(llbit), .csr_write_start(csr_write_start), .fail_count(fail_count)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic check_output(input logic [3:0] sel, input csr_pkg::csr_data_t expected);
        if (sel != NO_CHECK) begin
            @(negedge clk);
            chk_sel = sel;
            chk_exp = expected;
            check   = 1'b1;
            @(negedge clk);
            check   = 1'b0;
        end
    endtask

    // Data shows on rdata three edges after the latch edge
    task automatic write_reg(input csr_pkg::csr_addr_t a, input csr_pkg::csr_data_t d,
                             input logic [3:0] sel, input csr_pkg::csr_data_t expected);
        @(negedge clk);
        wen   = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wen   = 1'b0;
        // First idle cycle of the held write
        if (sel == SEL_WRITE_START) begin
            chk_sel = sel;
            chk_exp = expected;
            check   = 1'b1;
        end
        @(negedge clk);
        check = 1'b0;
        repeat (2) @(posedge clk);
        if (sel != SEL_WRITE_START) begin
            check_output(sel, expected);
        end
    endtask

    task automatic enter_exception(input csr_pkg::expcode_t code, input csr_pkg::csr_data_t pc);
        @(negedge clk);
        exception   = 1'b1;
        wen_expcode = 1'b1;
        wen_era     = 1'b1;
        wen_badv    = 1'b1;
        expcode     = code;
        era_in      = pc;
        badv_in     = {pc[15:0], pc[31:16]};
        @(negedge clk);
        exception   = 1'b0;
        wen_expcode = 1'b0;
        wen_era     = 1'b0;
        wen_badv    = 1'b0;
    endtask

    task automatic pulse_ertn();
        @(negedge clk);
        ertn = 1'b1;
        @(negedge clk);
        ertn = 1'b0;
    endtask

    task automatic pulse_llbit(input logic set, input logic clear);
        @(negedge clk);
        llbit_set   = set;
        llbit_clear = clear;
        @(negedge clk);
        llbit_set   = 1'b0;
        llbit_clear = 1'b0;
    endtask

    // Write is held by a stalled pipeline, then dropped
    task automatic flush_held_write(input csr_pkg::csr_addr_t a, input csr_pkg::csr_data_t d);
        @(negedge clk);
        d_idle = 1'b0;
        wen    = 1'b1;
        addr   = a;
        wdata  = d;
        @(negedge clk);
        wen    = 1'b0;
        @(negedge clk);
        flush  = 1'b1;
        @(negedge clk);
        flush  = 1'b0;
        d_idle = 1'b1;
        repeat (4) @(posedge clk);
    endtask

    task automatic wait_timer_irq(input logic [3:0] sel, input csr_pkg::csr_data_t expected);
        int cycles;
        cycles = 0;
        while (!estat[csr_pkg::TI_BIT] && cycles < timer_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (estat[csr_pkg::TI_BIT]) begin
            check_output(sel, expected);
        end else begin
            @(negedge clk);
            chk_sel     = sel;
            timeout_evt = 1'b1;
            @(negedge clk);
            timeout_evt = 1'b0;
        end
    endtask

    task automatic run_step(input step_t cur);
        case (cur.op)
            OP_WRITE: begin
                write_reg(cur.arg[13:0], cur.data, cur.sel, cur.expected);
                if (cur.arg[13:0] == csr_pkg::CSR_TCFG) begin
                    timer_limit = int'(cur.data >> 2) + TIMER_BIAS + 10;
                end
            end
            OP_CHECK: begin
                @(negedge clk);
                addr = cur.arg[13:0];
            end
            OP_EXCEPTION: enter_exception(cur.arg[6:0], cur.data);
            OP_ERTN:      pulse_ertn();
            OP_IRQ: begin
                @(negedge clk);
                hw_irq = cur.arg[7:0];
            end
            OP_LLBIT:     pulse_llbit(cur.arg[0], cur.arg[1]);
            OP_FLUSH:     flush_held_write(cur.arg[13:0], cur.data);
            default: ;
        endcase
        if (cur.op == OP_TIMER) begin
            wait_timer_irq(cur.sel, cur.expected);
        end else if (cur.op != OP_WRITE) begin
            check_output(cur.sel, cur.expected);
        end
    endtask

    initial begin
        int          fd;
        int          code;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_sel;
        logic [31:0] f_arg;
        logic [31:0] f_data;
        logic [31:0] f_exp;
        aresetn     = 1'b0;
        wen         = 1'b0;
        d_idle      = 1'b1;
        flush       = 1'b0;
        addr        = '0;
        wdata       = '0;
        exception   = 1'b0;
        ertn        = 1'b0;
        wen_expcode = 1'b0;
        expcode     = '0;
        wen_era     = 1'b0;
        era_in      = '0;
        wen_badv    = 1'b0;
        badv_in     = '0;
        llbit_set   = 1'b0;
        llbit_clear = 1'b0;
        hw_irq      = '0;
        check       = 1'b0;
        timeout_evt = 1'b0;
        done        = 1'b0;
        chk_sel     = NO_CHECK;
        chk_exp     = '0;
        timer_limit = CYCLES_PER_STEP;
        fd = $fopen("sim/csr_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/csr_stimulus.txt");
            $display("Test failures found");
            $finish;
        end else begin
            // Lines that do not hold five hex columns are comments
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0 && $sscanf(line, "%h %h %h %h %h",
                                        f_op, f_sel, f_arg, f_data, f_exp) == 5) begin
                    steps.push_back({f_op[3:0], f_sel[3:0], f_arg, f_data, f_exp});
                end
            end
            $fclose(fd);
            watchdog_cycles = steps.size() * CYCLES_PER_STEP + 8;
            loaded = 1'b1;
            repeat (8) @(posedge clk);
            @(negedge clk);
            aresetn = 1'b1;
            foreach (steps[i]) begin
                run_step(steps[i]);
            end
            @(negedge clk);
            done = 1'b1;
            @(negedge clk);
            done = 1'b0;
            if (fail_count == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Run stopped after %0d cycles before the stimulus was finished",
                 watchdog_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== sim/csr_stimulus.txt ====
# One step per line, all columns hex: op sel arg data expected
# op 0 write, 1 check, 2 exception, 3 ertn, 4 hw_irq, 5 llbit, 6 flush, 7 timer wait
# sel 0 rdata, 1 crmd, 2 estat, 3 era, 4 eentry, 5 cpu_interrupt, 6 idle_over, 7 llbit, f none
1 1 0 0 000000a8
1 7 0 0 00000001
0 0 30 deadbeef deadbeef
0 0 31 12345678 12345678
0 0 32 a5a55a5a a5a55a5a
0 0 33 ffffffff ffffffff
0 0 4 ffffffff 00001bff
0 0 c 12345fff 12345fc0
0 0 0 000000bf 000000af
0 0 0 000000a7 000000af
2 1 48 1c000100 000000a8
1 0 1 0 00000007
1 0 5 0 00480000
1 3 6 0 1c000100
1 0 7 0 01001c00
3 1 0 0 000000af
4 2 5 0 00480014
1 5 5 0 00000001
1 6 5 0 00000001
0 0 4 0 00000000
1 5 4 0 00000000
4 6 0 0 00000000
0 0 5 00000001 00480001
2 3 40 1c000200 1c000204
1 2 5 0 00000001
0 0 41 00000015 00000015
7 2 0 0 00000801
0 2 44 00000001 00000001
5 7 1 0 00000001
5 7 2 0 00000000
0 0 60 00000004 00000004
3 7 0 0 00000001
0 7 60 00000002 00000000
6 0 30 11111111 deadbeef

// ==== project.f ====
common/csr_pkg.sv
hdl/csr_write_stage.sv
exception/exception_csr.sv
timer/timer_csr.sv
hdl/save_llbit_csr.sv
hdl/csr_read_mux.sv
hdl/csr_top.sv
sim/csr_checker.sv
sim/tb_csr.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_csr -o tb_csr_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_csr_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q 'All tests passed!'; then
    exit 0
else
    exit 1
fi
